/* all.f */
source/hazardPkg.sv
source/stageReg.sv
source/hazardUnit.sv
source/pipelineControl.sv
dv/clockGen.sv
dv/pipelineControl_props.sv
dv/pipelineControlTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipelineControlTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TESTS FAILED
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/pipelineControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineControlTb
    import hazardPkg::*;
();

    localparam int clkPeriod = 4;
    localparam exeInfo_t noDest = '0;

    // one cycle of stimulus and the outputs expected in that cycle
    typedef struct packed {
        decodeInfo_t dec;
        stallReq_t   stallIn;
        flushReq_t   flushIn;
        stageCtrl_t  stallExp;
        stageCtrl_t  flushExp;
        fwdSel_t     fwd1Exp;
        fwdSel_t     fwd2Exp;
        logic        blankExp;
    } row_t;

    row_t rows[$];
    logic tableReady;
    int   rowIdx;

    logic        clk;
    logic        reset;
    decodeInfo_t decode;
    stallReq_t   stallReq;
    flushReq_t   flushReq;
    stageCtrl_t  stall;
    stageCtrl_t  flush;
    fwdSel_t     forward1D;
    fwdSel_t     forward2D;
    logic        longestStall;
    logic        stallDBlank;

    clockGen #(
        .halfPeriod  (clkPeriod / 2),
        .resetCycles (3)
    ) clockGen_i (
        .clk   (clk),
        .reset (reset)
    );

    pipelineControl pipelineControl_i (
        .clk          (clk),
        .reset        (reset),
        .decode       (decode),
        .stallReq     (stallReq),
        .flushReq     (flushReq),
        .stall        (stall),
        .flush        (flush),
        .forward1D    (forward1D),
        .forward2D    (forward2D),
        .longestStall (longestStall),
        .stallDBlank  (stallDBlank)
    );

    bind hazardUnit pipelineControlProps props_i (
        .clk         (pipelineControlTb.clk),
        .stall       (stall),
        .flush       (flush),
        .flushReq    (flushReq),
        .stallDBlank (stallDBlank)
    );

    function automatic exeInfo_t writes(input int idx);
        exeInfo_t info;
        info          = '0;
        info.regWrite = 1'b1;
        info.writeReg = regIdx_t'(idx);
        return info;
    endfunction

    function automatic exeInfo_t loads(input int idx);
        exeInfo_t info;
        info         = writes(idx);
        info.memRead = 1'b1;
        return info;
    endfunction

    function automatic exeInfo_t mfc0(input int idx);
        exeInfo_t info;
        info       = writes(idx);
        info.isMfc = 1'b1;
        return info;
    endfunction

    function automatic exeInfo_t mfhi(input int idx);
        exeInfo_t info;
        info           = writes(idx);
        info.hiloToReg = 1'b1;
        return info;
    endfunction

    function automatic decodeInfo_t instr(input int rs, input int rt, input exeInfo_t dest);
        decodeInfo_t d;
        d.rs   = regIdx_t'(rs);
        d.rt   = regIdx_t'(rt);
        d.dest = dest;
        return d;
    endfunction

    // stall bits {i, d, alu}, flush bits {jump, pred, exc}, stage bits {f, d, e, m, w}
    task automatic addRow(input decodeInfo_t dec, input logic [2:0] sIn, input logic [2:0] fIn,
                          input logic [4:0] sExp, input logic [4:0] fExp,
                          input fwdSel_t f1, input fwdSel_t f2, input int blank);
        row_t r;
        r.dec      = dec;
        r.stallIn  = sIn;
        r.flushIn  = fIn;
        r.stallExp = sExp;
        r.flushExp = fExp;
        r.fwd1Exp  = f1;
        r.fwd2Exp  = f2;
        r.blankExp = (blank != 0);
        rows.push_back(r);
    endtask

    task automatic buildTable();
        // three writers of r5 drain past a reader, r0 writer never forwards
        addRow(instr(0, 0, writes(0)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(0, 0, writes(5)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(0, 0, writes(5)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(0, 0, writes(5)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(5, 5, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdEx, fwdEx, 0);
        addRow(instr(5, 5, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdMem, fwdMem, 0);
        addRow(instr(5, 5, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdWb, fwdWb, 0);
        addRow(instr(5, 5, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        // load into r7, reader held one cycle in decode
        addRow(instr(0, 0, loads(7)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(7, 0, writes(8)), 3'b000, 3'b000, 5'b11000, 5'b00100, fwdEx, fwdNone, 1);
        addRow(instr(7, 0, writes(8)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdMem, fwdNone, 0);
        addRow(instr(0, 0, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        // icache then alu stall freeze the records
        addRow(instr(0, 0, writes(9)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(9, 8, writes(10)), 3'b100, 3'b000, 5'b11111, 5'b00000, fwdEx, fwdWb, 0);
        addRow(instr(9, 8, writes(10)), 3'b001, 3'b000, 5'b11111, 5'b00000, fwdEx, fwdWb, 0);
        addRow(instr(9, 8, writes(10)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdEx, fwdWb, 0);
        addRow(instr(9, 10, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdMem, fwdEx, 0);
        // exception during a dcache stall
        addRow(instr(10, 9, writes(11)), 3'b010, 3'b001, 5'b01110, 5'b01111, fwdMem, fwdWb, 0);
        addRow(instr(10, 9, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        // failed prediction with and without alu stall, then jump conflicts
        addRow(instr(0, 0, writes(12)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(12, 0, writes(13)), 3'b001, 3'b010, 5'b11111, 5'b01000, fwdEx, fwdNone, 0);
        addRow(instr(12, 0, writes(13)), 3'b000, 3'b010, 5'b00000, 5'b01100, fwdEx, fwdNone, 0);
        addRow(instr(12, 13, noDest), 3'b000, 3'b100, 5'b00000, 5'b01000, fwdMem, fwdNone, 0);
        addRow(instr(12, 0, noDest), 3'b100, 3'b100, 5'b11111, 5'b00000, fwdWb, fwdNone, 0);
        addRow(instr(0, 0, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        // mfc0 bubble, then mfhi whose bubble an exception cancels
        addRow(instr(0, 0, mfc0(14)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(0, 14, noDest), 3'b000, 3'b000, 5'b11000, 5'b00100, fwdNone, fwdEx, 1);
        addRow(instr(0, 14, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdMem, 0);
        addRow(instr(0, 0, mfhi(15)), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
        addRow(instr(15, 0, noDest), 3'b000, 3'b001, 5'b00000, 5'b01111, fwdEx, fwdNone, 0);
        addRow(instr(15, 0, noDest), 3'b000, 3'b000, 5'b00000, 5'b00000, fwdNone, fwdNone, 0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%0h expected 0x%0h (row %0d)", name, got, expected, rowIdx);
            $display("TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    initial begin
        decode     = '0;
        stallReq   = '0;
        flushReq   = '0;
        tableReady = 1'b0;
        rowIdx     = 0;
        buildTable();
        tableReady = 1'b1;
        wait (reset === 1'b0);
        for (rowIdx = 0; rowIdx < rows.size(); rowIdx++) begin
            @(posedge clk);
            #1;
            decode   = rows[rowIdx].dec;
            stallReq = rows[rowIdx].stallIn;
            flushReq = rows[rowIdx].flushIn;
            #2; // combinational outputs settled, next edge still 1 ns away
            checkValue("stall", 32'(stall), 32'(rows[rowIdx].stallExp));
            checkValue("flush", 32'(flush), 32'(rows[rowIdx].flushExp));
            checkValue("forward1D", 32'(forward1D), 32'(rows[rowIdx].fwd1Exp));
            checkValue("forward2D", 32'(forward2D), 32'(rows[rowIdx].fwd2Exp));
            checkValue("stallDBlank", 32'(stallDBlank), 32'(rows[rowIdx].blankExp));
            checkValue("longestStall", 32'(longestStall), 32'(rows[rowIdx].stallExp.e));
        end
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog, sized from the table plus slack for reset
    initial begin
        wait (tableReady === 1'b1);
        #((rows.size() + 20) * clkPeriod);
        $display("timeout: the stimulus table did not complete in the expected time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* dv/pipelineControl_props.sv */
`timescale 1ns/1ps
`default_nettype none

// hazard unit invariants, bound into hazardUnit
module pipelineControlProps import hazardPkg::*; (
    input wire        clk,
    input stageCtrl_t stall,
    input stageCtrl_t flush,
    input flushReq_t  flushReq,
    input wire        stallDBlank
);

    // fetch is only ever held, never flushed
    fetchNeverFlushed: assert property (@(posedge clk) !flush.f)
        else $error("fetch flush strobe went high");

    // writeback has to retire while the exception redirect is taken
    wbRunsOnException: assert property (@(posedge clk) !(stall.w && flushReq.exceptionM))
        else $error("writeback stalled during an exception");

    bubbleHoldsDecode: assert property (@(posedge clk) stallDBlank |-> stall.d)
        else $error("load-use bubble without a decode stall");

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock plus a synchronous reset held for a few cycles
module clockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0; // released off the edge, like the stimulus
    end

endmodule

`default_nettype wire

/* source/pipelineControl.sv */
`timescale 1ns/1ps
`default_nettype none

// pipeline control top: hazard unit plus the ex/mem/wb destination trackers
module pipelineControl import hazardPkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  decodeInfo_t decode,
    input  stallReq_t   stallReq,
    input  flushReq_t   flushReq,
    output stageCtrl_t  stall,
    output stageCtrl_t  flush,
    output fwdSel_t     forward1D,
    output fwdSel_t     forward2D,
    output logic        longestStall,
    output logic        stallDBlank
);

    exeInfo_t exeQ;
    memInfo_t memD;
    memInfo_t memQ;
    wbInfo_t  wbD;
    wbInfo_t  wbQ;

    // execute keeps the full decode destination record
    stageReg #(
        .payload_t (exeInfo_t)
    ) exeReg (
        .clk   (clk),
        .reset (reset),
        .stall (stall.e),
        .flush (flush.e),
        .d     (decode.dest),
        .q     (exeQ)
    );

    // memory drops the cp0 and hilo flags
    assign memD.regWrite = exeQ.regWrite;
    assign memD.writeReg = exeQ.writeReg;
    assign memD.memRead  = exeQ.memRead;

    stageReg #(
        .payload_t (memInfo_t)
    ) memReg (
        .clk   (clk),
        .reset (reset),
        .stall (stall.m),
        .flush (flush.m),
        .d     (memD),
        .q     (memQ)
    );

    // writeback only needs the write port
    assign wbD.regWrite = memQ.regWrite;
    assign wbD.writeReg = memQ.writeReg;

    stageReg #(
        .payload_t (wbInfo_t)
    ) wbReg (
        .clk   (clk),
        .reset (reset),
        .stall (stall.w),
        .flush (flush.w),
        .d     (wbD),
        .q     (wbQ)
    );

    hazardUnit hazardUnit_i (
        .rsD          (decode.rs),
        .rtD          (decode.rt),
        .exeInfo      (exeQ),
        .memInfo      (memQ),
        .wbInfo       (wbQ),
        .stallReq     (stallReq),
        .flushReq     (flushReq),
        .forward1D    (forward1D),
        .forward2D    (forward2D),
        .stall        (stall),
        .flush        (flush),
        .longestStall (longestStall),
        .stallDBlank  (stallDBlank)
    );

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

// forwarding selects, load-use bubble and the per-stage stall/flush strobes
module hazardUnit import hazardPkg::*; (
    input  regIdx_t    rsD,
    input  regIdx_t    rtD,
    input  exeInfo_t   exeInfo,
    input  memInfo_t   memInfo,
    input  wbInfo_t    wbInfo,
    input  stallReq_t  stallReq,
    input  flushReq_t  flushReq,
    output fwdSel_t    forward1D,
    output fwdSel_t    forward2D,
    output stageCtrl_t stall,
    output stageCtrl_t flush,
    output logic       longestStall,
    output logic       stallDBlank
);

    logic cacheStall;
    logic aluStall;
    logic exception;
    logic predFailed;
    logic jumpConflict;
    logic exeLateResult; // ex result only known after memory / cp0 / hilo read
    logic needsEx;

    // youngest writer wins: execute, then memory, then writeback
    function automatic fwdSel_t pickSource(
        input regIdx_t  src,
        input exeInfo_t exe,
        input memInfo_t mem,
        input wbInfo_t  wb
    );
        fwdSel_t sel;
        logic    live;
        live = (src != '0); // r0 never forwards
        sel  = fwdNone;
        if (live && exe.regWrite && (exe.writeReg == src)) begin
            sel = fwdEx;
        end else if (live && mem.regWrite && (mem.writeReg == src)) begin
            sel = fwdMem;
        end else if (live && wb.regWrite && (wb.writeReg == src)) begin
            sel = fwdWb;
        end
        return sel;
    endfunction

    assign forward1D = pickSource(rsD, exeInfo, memInfo, wbInfo);
    assign forward2D = pickSource(rtD, exeInfo, memInfo, wbInfo);

    assign cacheStall   = stallReq.iCacheStall | stallReq.dCacheStall;
    assign aluStall     = stallReq.aluStall;
    assign exception    = flushReq.exceptionM;
    assign predFailed   = flushReq.predFailedM;
    assign jumpConflict = flushReq.jumpConflictE;

    assign longestStall = cacheStall | aluStall;

    // load-use: decode needs a value execute cannot forward this cycle
    assign exeLateResult = exeInfo.memRead | exeInfo.isMfc | exeInfo.hiloToReg;
    assign needsEx       = (forward1D == fwdEx) | (forward2D == fwdEx);
    assign stallDBlank   = needsEx & exeLateResult & ~exception;

    always_comb begin
        // fetch and writeback keep moving on an exception so the redirect lands
        stall.f = (longestStall & ~exception) | stallDBlank;
        stall.d = longestStall | stallDBlank;
        stall.e = longestStall;
        stall.m = longestStall;
        stall.w = longestStall & ~exception;
    end

    always_comb begin
        flush.f = 1'b0;
        flush.d = exception | predFailed | (jumpConflict & ~stall.d);
        // bubble into execute while decode waits, unless execute is held too
        flush.e = exception | (predFailed & ~aluStall) | (stallDBlank & ~stall.e);
        flush.m = exception;
        flush.w = exception;
    end

endmodule

`default_nettype wire

/* source/stageReg.sv */
`timescale 1ns/1ps
`default_nettype none

// pipeline register for one stage's destination record
// the payload type is chosen by the instantiating level
module stageReg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      stall,
    input  wire      flush,
    input  payload_t d,
    output payload_t q
);

    payload_t held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
        end else if (flush) begin
            // a zero record is a bubble, regWrite is low
            held <= '0;
        end else if (!stall) begin
            held <= d;
        end
        // stall without flush keeps the current record
    end

    assign q = held;

endmodule

`default_nettype wire

/* source/hazardPkg.sv */
`default_nettype none

package hazardPkg;

    // architectural register index, r0 is hardwired to zero
    typedef logic [4:0] regIdx_t;

    // forwarding source for a decode operand
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdMem  = 2'b01,
        fwdWb   = 2'b10,
        fwdEx   = 2'b11  // value not ready yet if the ex instr is a load-like op
    } fwdSel_t;

    // destination record of the instruction in execute
    typedef struct packed {
        logic    regWrite;
        regIdx_t writeReg;
        logic    memRead;   // lw, lb, lh and friends
        logic    isMfc;     // cp0 read
        logic    hiloToReg; // mfhi / mflo
    } exeInfo_t;

    // destination record of the instruction in memory
    typedef struct packed {
        logic    regWrite;
        regIdx_t writeReg;
        logic    memRead;
    } memInfo_t;

    // destination record of the instruction in writeback
    typedef struct packed {
        logic    regWrite;
        regIdx_t writeReg;
    } wbInfo_t;

    // what decode hands over each cycle
    typedef struct packed {
        regIdx_t  rs;
        regIdx_t  rt;
        exeInfo_t dest;
    } decodeInfo_t;

    typedef struct packed {
        logic iCacheStall;
        logic dCacheStall;
        logic aluStall;   // multi-cycle mul/div in execute
    } stallReq_t;

    typedef struct packed {
        logic jumpConflictE;
        logic predFailedM;
        logic exceptionM;
    } flushReq_t;

    // one strobe per pipeline stage
    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stageCtrl_t;

endpackage

`default_nettype wire
